// File: hdl/vga_pkg.sv
// Shared types for the bit-plane display controller
// Frame word with one bit per pixel in each colour plane
// 3-3-2 output colour and the host write bundle

package vga_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// Pixels carried by one frame word, one bit per pixel and plane
	localparam int word_w = 32;

	// Frame memory address width seen by the host and the fetcher
	localparam int addr_w = 16;

	////////////////////////////////////////
	// Frame memory word
	////////////////////////////////////////

	// Bit i of each plane belongs to pixel i of the word
	// The three planes are stored side by side in a single 96 bit word
	typedef struct packed {
		logic [word_w-1:0] red;
		logic [word_w-1:0] green;
		logic [word_w-1:0] blue;
	} frame_word_t;

	////////////////////////////////////////
	// Output colour
	////////////////////////////////////////

	// Red and green get three bits, blue gets two
	// Each plane bit is replicated to full intensity by the fetcher
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgb332_t;

	////////////////////////////////////////
	// Host write
	////////////////////////////////////////

	// One frame word and its address, taken on a single cycle strobe
	// Address is row times words per row plus the word index in the row
	typedef struct packed {
		logic [addr_w-1:0] addr;
		frame_word_t       data;
	} host_wr_t;

endpackage

// File: hdl/vga_timing.sv
// Display timing controller
// Horizontal and vertical counters, registered sync and data enable
// Fetch strobes for the line fetcher

`timescale 1ns/1ps

module vga_timing #(
	parameter int h_total    = 800,
	parameter int h_sync     = 96,
	parameter int h_start    = 144,
	parameter int v_total    = 525,
	parameter int v_sync     = 2,
	parameter int v_start    = 35,
	parameter int img_words  = 10,
	parameter int img_h      = 240,
	parameter int pix_scale  = 2,
	parameter int line_scale = 2
) (
	input  logic clk,
	input  logic reset,
	output logic hsync,
	output logic vsync,
	output logic de,
	output logic pix_en,
	output logic line_start,
	output logic frame_start
);
	import vga_pkg::*;

	// End of the visible window, one past the last visible count
	localparam int h_end = h_start + img_words * word_w * pix_scale;
	localparam int v_end = v_start + img_h * line_scale;

	localparam int h_w = $clog2(h_total);
	localparam int v_w = $clog2(v_total);

	logic [h_w-1:0] h_cnt;
	logic [v_w-1:0] v_cnt;
	logic           h_act;
	logic           v_act;

	////////////////////////////////////////
	// Counters
	////////////////////////////////////////

	// Clock count within the line and line count within the frame
	// The line count steps on the last clock of every line
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (int'(h_cnt) == h_total - 1) begin
			h_cnt <= '0;
			if (int'(v_cnt) == v_total - 1) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Window decode
	////////////////////////////////////////

	// Visible clocks of a line and visible lines of a frame
	assign h_act = (int'(h_cnt) >= h_start) && (int'(h_cnt) < h_end);
	assign v_act = (int'(v_cnt) >= v_start) && (int'(v_cnt) < v_end);

	// Pixel enable leads de by one clock since de is registered below
	assign pix_en = h_act && v_act;

	// Clock 0 of a visible line leaves h_start clocks for the first read
	// The fetcher needs three of them to get word 0 into its buffer
	assign line_start = (h_cnt == '0) && v_act;

	// Only the first visible line restarts the image at row 0
	assign frame_start = (h_cnt == '0) && (int'(v_cnt) == v_start);

	////////////////////////////////////////
	// Registered outputs
	////////////////////////////////////////

	// Both syncs are active low and idle high out of reset
	// All three outputs trail the counter state by one clock
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			de    <= 1'b0;
		end else begin
			hsync <= !(int'(h_cnt) < h_sync);
			vsync <= !(int'(v_cnt) < v_sync);
			de    <= pix_en;
		end
	end

endmodule

// File: hdl/vga_frame_ram.sv
// Frame memory
// One host write port and one registered read port

`timescale 1ns/1ps

module vga_frame_ram #(
	parameter int depth = 2400
) (
	input  logic                       clk,
	input  logic                       wr_stb,
	input  vga_pkg::host_wr_t          wr,
	input  logic                       rd_en,
	input  logic [vga_pkg::addr_w-1:0] rd_addr,
	output vga_pkg::frame_word_t       rd_data
);
	import vga_pkg::*;

	// Index width of the storage array
	localparam int aw = (depth > 1) ? $clog2(depth) : 1;

	// One entry per frame word, image rows laid out one after another
	frame_word_t mem [depth];

	logic wr_hit;

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	// Writes outside the image are dropped rather than aliased
	assign wr_hit = wr_stb && (int'(wr.addr) < depth);

	// Host strobe writes the whole word in the same cycle
	always_ff @(posedge clk) begin
		if (wr_hit) begin
			mem[wr.addr[aw-1:0]] <= wr.data;
		end
	end

	////////////////////////////////////////
	// Read port
	////////////////////////////////////////

	// Data appears on the clock after rd_en
	// A write to the same address in that cycle is not seen yet,
	// the old word comes out
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr[aw-1:0]];
		end
	end

endmodule

// File: hdl/vga_line_fetch.sv
// Line fetcher
// Reads frame words per line with a one word prefetch
// Serializes scaled pixels and expands them to 3-3-2 colour

`timescale 1ns/1ps

module vga_line_fetch #(
	parameter int img_words  = 10,
	parameter int img_h      = 240,
	parameter int pix_scale  = 2,
	parameter int line_scale = 2
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       frame_start,
	input  logic                       line_start,
	input  logic                       pix_en,
	output logic                       rd_en,
	output logic [vga_pkg::addr_w-1:0] rd_addr,
	input  vga_pkg::frame_word_t       rd_data,
	output vga_pkg::rgb332_t           rgb
);
	import vga_pkg::*;

	localparam int row_w = (img_h > 1) ? $clog2(img_h) : 1;
	localparam int rep_w = (line_scale > 1) ? $clog2(line_scale) : 1;
	localparam int wd_w  = $clog2(img_words + 2);
	localparam int bit_w = $clog2(word_w);
	localparam int sc_w  = (pix_scale > 1) ? $clog2(pix_scale) : 1;

	// Image position
	logic [row_w-1:0]  row;
	logic [rep_w-1:0]  line_rep;
	logic [wd_w-1:0]   word_idx;
	logic [bit_w-1:0]  bit_idx;
	logic [sc_w-1:0]   scale_cnt;
	logic [addr_w-1:0] line_base;

	// Read tracking, tgt is 0 for the current buffer and 1 for the next
	logic prime;
	logic rd_tgt;
	logic vld;
	logic vld_tgt;

	frame_word_t cur_buf;
	frame_word_t nxt_buf;

	logic [row_w-1:0]  row_eff;
	logic [rep_w-1:0]  rep_eff;
	logic [addr_w-1:0] base_now;
	logic              pix_last;
	logic              swap;
	logic              more;
	rgb332_t           pix_rgb;

	////////////////////////////////////////
	// Position decode
	////////////////////////////////////////

	// frame_start lands on the first line_start, so that line sees row 0
	assign row_eff  = frame_start ? '0 : row;
	assign rep_eff  = frame_start ? '0 : line_rep;
	assign base_now = addr_w'(int'(row_eff) * img_words);

	// Last clock of a pixel, and of the last pixel of a word
	assign pix_last = (int'(scale_cnt) == pix_scale - 1);
	assign swap     = pix_en && pix_last && (int'(bit_idx) == word_w - 1);

	// Whether the word two ahead of the one on screen still exists
	assign more = (int'(word_idx) + 2 < img_words);

	////////////////////////////////////////
	// Counters and read requests
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			row       <= '0;
			line_rep  <= '0;
			word_idx  <= '0;
			bit_idx   <= '0;
			scale_cnt <= '0;
			line_base <= '0;
			prime     <= 1'b0;
			rd_en     <= 1'b0;
			rd_addr   <= '0;
			rd_tgt    <= 1'b0;
			vld       <= 1'b0;
			vld_tgt   <= 1'b0;
		end else begin
			rd_en   <= 1'b0;
			vld     <= rd_en;
			vld_tgt <= rd_tgt;
			if (line_start) begin
				// Word 0 of this row goes straight into the current buffer
				line_base <= base_now;
				rd_en     <= 1'b1;
				rd_addr   <= base_now;
				rd_tgt    <= 1'b0;
				prime     <= (img_words > 1);
				word_idx  <= '0;
				bit_idx   <= '0;
				scale_cnt <= '0;
				// Row moves on once it has been shown line_scale times
				if (int'(rep_eff) == line_scale - 1) begin
					line_rep <= '0;
					row <= (int'(row_eff) == img_h - 1) ? '0 : row_eff + 1'b1;
				end else begin
					line_rep <= rep_eff + 1'b1;
					row      <= row_eff;
				end
			end else begin
				// Word 1 follows one clock behind word 0
				if (prime) begin
					prime   <= 1'b0;
					rd_en   <= 1'b1;
					rd_addr <= line_base + 1'b1;
					rd_tgt  <= 1'b1;
				end
				if (pix_en) begin
					if (pix_last) begin
						scale_cnt <= '0;
						bit_idx   <= bit_idx + 1'b1;
					end else begin
						scale_cnt <= scale_cnt + 1'b1;
					end
					// At a word boundary refill the prefetch buffer
					if (swap) begin
						word_idx <= word_idx + 1'b1;
						if (more) begin
							rd_en   <= 1'b1;
							rd_addr <= line_base + addr_w'(word_idx) + addr_w'(2);
							rd_tgt  <= 1'b1;
						end
					end
				end
			end
		end
	end

	////////////////////////////////////////
	// Word buffers
	////////////////////////////////////////

	// Refill of nxt_buf lands two clocks after a swap,
	// well before the next swap
	always_ff @(posedge clk) begin
		if (vld && !vld_tgt) begin
			cur_buf <= rd_data;
		end else if (swap) begin
			cur_buf <= nxt_buf;
		end
		if (vld && vld_tgt) begin
			nxt_buf <= rd_data;
		end
	end

	////////////////////////////////////////
	// Colour output
	////////////////////////////////////////

	// Replicate each plane bit up to the width of its colour field
	assign pix_rgb.red   = {3{cur_buf.red[bit_idx]}};
	assign pix_rgb.green = {3{cur_buf.green[bit_idx]}};
	assign pix_rgb.blue  = {2{cur_buf.blue[bit_idx]}};

	// Registered on pix_en so rgb lines up with de, black outside
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rgb <= '0;
		end else if (pix_en) begin
			rgb <= pix_rgb;
		end else begin
			rgb <= '0;
		end
	end

endmodule

// File: hdl/vga_display_top.sv
// Display controller top level
// Timing controller, frame memory and line fetcher

`timescale 1ns/1ps

module vga_display_top #(
	parameter int h_total    = 800,
	parameter int h_sync     = 96,
	parameter int h_start    = 144,
	parameter int v_total    = 525,
	parameter int v_sync     = 2,
	parameter int v_start    = 35,
	parameter int img_words  = 10,
	parameter int img_h      = 240,
	parameter int pix_scale  = 2,
	parameter int line_scale = 2
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              wr_stb,
	input  vga_pkg::host_wr_t wr,
	output logic              hsync,
	output logic              vsync,
	output logic              de,
	output vga_pkg::rgb332_t  rgb
);
	import vga_pkg::*;

	// One memory word per word of every image row
	localparam int depth = img_words * img_h;

	logic              frame_start;
	logic              line_start;
	logic              pix_en;
	logic              rd_en;
	logic [addr_w-1:0] rd_addr;
	frame_word_t       rd_data;

	// Counters, sync generation and fetch strobes
	vga_timing #(
		.h_total    (h_total),
		.h_sync     (h_sync),
		.h_start    (h_start),
		.v_total    (v_total),
		.v_sync     (v_sync),
		.v_start    (v_start),
		.img_words  (img_words),
		.img_h      (img_h),
		.pix_scale  (pix_scale),
		.line_scale (line_scale)
	) timing_i (
		.clk         (clk),
		.reset       (reset),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.pix_en      (pix_en),
		.line_start  (line_start),
		.frame_start (frame_start)
	);

	// Image storage, host writes in and fetch reads out
	vga_frame_ram #(
		.depth (depth)
	) ram_i (
		.clk     (clk),
		.wr_stb  (wr_stb),
		.wr      (wr),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// Pixel stream for the visible window
	vga_line_fetch #(
		.img_words  (img_words),
		.img_h      (img_h),
		.pix_scale  (pix_scale),
		.line_scale (line_scale)
	) fetch_i (
		.clk         (clk),
		.reset       (reset),
		.frame_start (frame_start),
		.line_start  (line_start),
		.pix_en      (pix_en),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.rgb         (rgb)
	);

endmodule

// File: verification/vga_display_tb.sv
// Testbench for the bit-plane display controller
// Clock, reset, DUT with small timing, image model and directed tests
// Covers reset state, sync timing, image content, scaling and live update

`timescale 1ns/1ps

module vga_display_tb;
	import vga_pkg::*;

	// Small screen so that one frame is only 8000 clocks
	localparam int h_total    = 200;
	localparam int h_sync     = 16;
	localparam int h_start    = 24;
	localparam int v_total    = 40;
	localparam int v_sync     = 2;
	localparam int v_start    = 4;
	localparam int img_words  = 2;
	localparam int img_h      = 6;
	localparam int pix_scale  = 2;
	localparam int line_scale = 3;

	localparam int de_len     = img_words * word_w * pix_scale;
	localparam int act_lines  = img_h * line_scale;
	localparam int frame_clks = v_total * h_total;
	localparam int n_words    = img_words * img_h;

	logic     clk;
	logic     reset;
	logic     wr_stb;
	host_wr_t wr;
	logic     hsync;
	logic     vsync;
	logic     de;
	rgb332_t  rgb;

	// Image as the host wrote it with one entry per frame word
	frame_word_t model [n_words];

	integer seed;
	int     test_errs;
	int     total_errs;
	int     tests_run;
	int     tests_failed;
	logic   edge_ok;

	vga_display_top #(
		.h_total    (h_total),
		.h_sync     (h_sync),
		.h_start    (h_start),
		.v_total    (v_total),
		.v_sync     (v_sync),
		.v_start    (v_start),
		.img_words  (img_words),
		.img_h      (img_h),
		.pix_scale  (pix_scale),
		.line_scale (line_scale)
	) dut_i (
		.clk    (clk),
		.reset  (reset),
		.wr_stb (wr_stb),
		.wr     (wr),
		.hsync  (hsync),
		.vsync  (vsync),
		.de     (de),
		.rgb    (rgb)
	);

	// Period of 40 ns with the first rising edge at 20 ns
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////
	// Reporting
	////////////////////////////////////////

	task automatic value_error(input string sig, input int got, input int exp);
		test_errs++;
		$display("** Error at %0d ns: %s = %0h, expected %0h", $time, sig, got, exp);
	endtask

	task automatic plain_error(input string msg);
		test_errs++;
		$display("Error at %0d ns: %s", $time, msg);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	////////////////////////////////////////
	// Stimulus and reference helpers
	////////////////////////////////////////

	// One strobe per word driven on the falling edge
	task automatic write_word(input int addr, input frame_word_t data);
		@(negedge clk);
		wr_stb  = 1'b1;
		wr.addr = 16'(addr);
		wr.data = data;
		model[addr] = data;
		@(negedge clk);
		wr_stb = 1'b0;
		wr     = '0;
	endtask

	// Returns on the first falling clock edge that sees vsync low
	// The counters are then at clock 1 of line 0
	task automatic wait_vsync_fall();
		logic prev;
		int   n;
		edge_ok = 1'b0;
		prev    = vsync;
		for (n = 0; n < 2 * frame_clks && !edge_ok; n++) begin
			@(negedge clk);
			if (prev && !vsync) begin
				edge_ok = 1'b1;
			end
			prev = vsync;
		end
		if (!edge_ok) begin
			plain_error("vsync never fell within two frames");
		end
	endtask

	// Colour of pixel col in image row row with each plane bit widened
	function automatic rgb332_t expect_rgb(input int row, input int col);
		frame_word_t w;
		int          b;
		rgb332_t     c;
		w       = model[row * img_words + col / word_w];
		b       = col % word_w;
		c.red   = {3{w.red[b]}};
		c.green = {3{w.green[b]}};
		c.blue  = {2{w.blue[b]}};
		return c;
	endfunction

	// Compares every output cycle of the next full frame with the model
	task automatic check_frame();
		int      t;
		int      line;
		int      n;
		int      de_cycles;
		logic    prev_de;
		rgb332_t exp;
		wait_vsync_fall();
		if (edge_ok) begin
			line      = -1;
			n         = 0;
			de_cycles = 0;
			prev_de   = 1'b0;
			for (t = 1; t < frame_clks; t++) begin
				@(negedge clk);
				if (de) begin
					if (!prev_de) begin
						line++;
						n = 0;
					end
					// The n-th de cycle of a line shows pixel n / pix_scale
					if (line < act_lines) begin
						exp = expect_rgb(line / line_scale, n / pix_scale);
						if (rgb !== exp) begin
							value_error("rgb", int'(rgb), int'(exp));
						end
					end
					n++;
					de_cycles++;
				end else if (rgb !== 8'h00) begin
					value_error("rgb", int'(rgb), 0);
				end
				prev_de = de;
			end
			if (de_cycles != act_lines * de_len) begin
				value_error("de cycle count", de_cycles, act_lines * de_len);
			end
		end
	endtask

	task automatic check_idle();
		if (hsync !== 1'b1) value_error("hsync", int'(hsync), 1);
		if (vsync !== 1'b1) value_error("vsync", int'(vsync), 1);
		if (de !== 1'b0) value_error("de", int'(de), 0);
		if (rgb !== 8'h00) value_error("rgb", int'(rgb), 0);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_reset();
		int i;
		for (i = 0; i < 3; i++) begin
			@(negedge clk);
			check_idle();
		end
		reset = 1'b0;
		#1;
		// Counters sit at line 0 clock 0 while the outputs still show the reset values
		check_idle();
		@(negedge clk);
		// One clock later line 0 clock 0 has reached both syncs
		if (hsync !== 1'b0) value_error("hsync", int'(hsync), 0);
		if (vsync !== 1'b0) value_error("vsync", int'(vsync), 0);
		end_test("reset state");
	endtask

	task automatic test_horizontal();
		int   t;
		int   last_fall;
		int   de_start;
		int   lines;
		logic ph;
		logic pd;
		wait_vsync_fall();
		if (edge_ok) begin
			last_fall = 0;
			de_start  = 0;
			lines     = 0;
			ph        = 1'b0;
			pd        = 1'b0;
			for (t = 1; t <= frame_clks; t++) begin
				@(negedge clk);
				if (!ph && hsync && t - last_fall != h_sync) begin
					value_error("hsync low time", t - last_fall, h_sync);
				end
				if (ph && !hsync) begin
					if (t - last_fall != h_total) begin
						value_error("hsync period", t - last_fall, h_total);
					end
					last_fall = t;
				end
				if (!pd && de) begin
					if (t - last_fall != h_start) begin
						value_error("de start offset", t - last_fall, h_start);
					end
					de_start = t;
				end
				if (pd && !de) begin
					if (t - de_start != de_len) begin
						value_error("de length", t - de_start, de_len);
					end
					lines++;
				end
				ph = hsync;
				pd = de;
			end
			if (lines != act_lines) value_error("de lines", lines, act_lines);
		end
		end_test("horizontal timing");
	endtask

	task automatic test_vertical();
		int   t;
		int   falls;
		int   lines;
		logic pv;
		logic pd;
		wait_vsync_fall();
		if (edge_ok) begin
			falls = 0;
			lines = 0;
			pv    = 1'b0;
			pd    = 1'b0;
			for (t = 1; t <= frame_clks; t++) begin
				@(negedge clk);
				if (!pv && vsync && t != v_sync * h_total) begin
					value_error("vsync low time", t, v_sync * h_total);
				end
				if (pv && !vsync) begin
					falls++;
					if (t != frame_clks) value_error("vsync period", t, frame_clks);
				end
				if (!pd && de && t < frame_clks) begin
					lines++;
				end
				pv = vsync;
				pd = de;
			end
			if (falls != 1) plain_error("vsync did not fall exactly once per frame");
			if (lines != act_lines) value_error("de lines", lines, act_lines);
		end
		end_test("vertical timing");
	endtask

	task automatic test_image();
		frame_word_t w;
		int          a;
		for (a = 0; a < n_words; a++) begin
			w.red   = $random(seed);
			w.green = $random(seed);
			w.blue  = $random(seed);
			write_word(a, w);
		end
		check_frame();
		end_test("image content");
	endtask

	task automatic test_scaling();
		frame_word_t w;
		int          a;
		int          b;
		int          t;
		int          run;
		int          line_run;
		int          lines;
		logic        bv;
		logic        prev_de;
		rgb332_t     prev_rgb;
		rgb332_t     first_prev;
		// Checkerboard so that neighbouring pixels and rows always differ
		for (a = 0; a < n_words; a++) begin
			for (b = 0; b < word_w; b++) begin
				bv         = 1'((a / img_words + (a % img_words) * word_w + b) % 2);
				w.red[b]   = bv;
				w.green[b] = !bv;
				w.blue[b]  = bv;
			end
			write_word(a, w);
		end
		wait_vsync_fall();
		if (edge_ok) begin
			run        = 0;
			line_run   = 0;
			lines      = 0;
			prev_de    = 1'b0;
			prev_rgb   = '0;
			first_prev = '0;
			for (t = 1; t < frame_clks; t++) begin
				@(negedge clk);
				if (de && !prev_de) begin
					// First pixel of a line tells which row is shown
					if (lines > 0 && rgb == first_prev) begin
						line_run++;
					end else begin
						if (lines > 0 && line_run != line_scale) begin
							value_error("row repeat", line_run, line_scale);
						end
						line_run = 1;
					end
					first_prev = rgb;
					lines++;
					run = 1;
				end else if (de && rgb == prev_rgb) begin
					run++;
				end else if (de) begin
					if (run != pix_scale) value_error("pixel hold", run, pix_scale);
					run = 1;
				end else if (prev_de && run != pix_scale) begin
					value_error("pixel hold", run, pix_scale);
				end
				prev_rgb = rgb;
				prev_de  = de;
			end
			if (line_run != line_scale) value_error("row repeat", line_run, line_scale);
			if (lines != act_lines) value_error("de lines", lines, act_lines);
		end
		end_test("pixel and line scaling");
	endtask

	task automatic test_update();
		frame_word_t w;
		int          addr;
		wait_vsync_fall();
		if (edge_ok) begin
			// Line 0 is in vertical blanking and the first active line is still far off
			addr    = int'($unsigned($random(seed)) % n_words);
			w.red   = $random(seed);
			w.green = $random(seed);
			w.blue  = $random(seed);
			write_word(addr, w);
		end
		check_frame();
		end_test("update during display");
	endtask

	////////////////////////////////////////
	// Sequence
	////////////////////////////////////////

	initial begin
		seed         = 32'h66a6_e62e;
		reset        = 1'b1;
		wr_stb       = 1'b0;
		wr           = '0;
		test_errs    = 0;
		total_errs   = 0;
		tests_run    = 0;
		tests_failed = 0;
		edge_ok      = 1'b0;
		test_reset();
		test_horizontal();
		test_vertical();
		test_image();
		test_scaling();
		test_update();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
		if (tests_failed == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: vga_display.f
hdl/vga_pkg.sv
hdl/vga_timing.sv
hdl/vga_frame_ram.sv
hdl/vga_line_fetch.sv
hdl/vga_display_top.sv
verification/vga_display_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the display controller testbench with Verilator and runs it.
# The exit status is nonzero unless the log holds the pass line.

set -e

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log
sim_bin=vga_display_sim

rm -rf "$build_dir" "$log_file"

verilator --binary --timing \
	--top-module vga_display_tb \
	-f vga_display.f \
	--Mdir "$build_dir" \
	-o "$sim_bin"

"./$build_dir/$sim_bin" | tee "$log_file"

if grep -q "^>>> PASS$" "$log_file"; then
	echo "Simulation passed, log in $log_file"
	exit 0
fi

echo "Simulation failed, see $log_file"
exit 1
